//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_uart_mem_system -Mdir obj_dir
	-./obj_dir/Vtb_uart_mem_system > sim.log 2>&1
	cat sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hdl/mem_pkg.sv
package mem_pkg;

    // host side word and address widths.
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BYTES_PER_WORD = 4;

    // first byte of every request frame.
    localparam logic [7:0] CMD_READ  = 8'd0;
    localparam logic [7:0] CMD_WRITE = 8'd1;

    // remote memory, word addressed; upper address bits alias.
    localparam int MEM_INDEX_W = 6;
    localparam int MEM_WORDS   = 64;

endpackage

//--- hdl/uart_mem_bridge.sv
module uart_mem_bridge (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_start,
    input  logic                      cmd_write,
    output logic                      cmd_ready,
    input  logic [mem_pkg::ADDR_W-1:0] addr,
    input  logic [mem_pkg::DATA_W-1:0] wdata,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic                      rdata_valid,
    output logic                      serial_out,
    input  logic                      serial_in
);

    typedef enum logic [2:0] {IDLE, SEND, GAP, RECV, DONE} state_t;

    state_t     state;
    logic [3:0] idx;        // bytes sent, then bytes received.
    logic       write_q;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_ready;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       accept;

    // command byte, address and write data, sent from the top byte down.
    logic [8+mem_pkg::ADDR_W+mem_pkg::DATA_W-1:0] frame;

    assign accept = cmd_start && cmd_ready;

    uart_tx u_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .start (tx_start),
        .data  (tx_data),
        .ready (tx_ready),
        .line  (serial_out)
    );

    uart_rx u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .line  (serial_in),
        .data  (rx_data),
        .valid (rx_valid)
    );

    always_ff @(posedge clk) begin
        if (accept)
            frame <= {cmd_write ? mem_pkg::CMD_WRITE : mem_pkg::CMD_READ, addr, wdata};
        else if (state == SEND && tx_ready)
            frame <= frame << 8;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            idx         <= '0;
            write_q     <= 1'b0;
            tx_start    <= 1'b0;
            tx_data     <= '0;
            cmd_ready   <= 1'b1;
            rdata       <= '0;
            rdata_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: if (accept) begin
                    write_q   <= cmd_write;
                    idx       <= '0;
                    cmd_ready <= 1'b0;
                    state     <= SEND;
                end
                SEND: if (tx_ready) begin
                    tx_start <= 1'b1;
                    tx_data  <= frame[$high(frame) -: 8];
                    idx      <= idx + 1'b1;
                    state    <= GAP;
                end
                GAP: begin
                    // the transmitter takes the byte here, so ready is low next cycle.
                    tx_start <= 1'b0;
                    if (write_q && idx == 4'(1 + 2 * mem_pkg::BYTES_PER_WORD)) begin
                        state <= DONE;
                    end else if (!write_q && idx == 4'(1 + mem_pkg::BYTES_PER_WORD)) begin
                        idx   <= '0;
                        state <= RECV;
                    end else begin
                        state <= SEND;
                    end
                end
                RECV: if (rx_valid) begin
                    rdata <= {rdata[mem_pkg::DATA_W-9:0], rx_data};    // msb first.
                    idx   <= idx + 1'b1;
                    if (idx == 4'(mem_pkg::BYTES_PER_WORD - 1)) begin
                        rdata_valid <= 1'b1;
                        state       <= DONE;
                    end
                end
                DONE: begin
                    rdata_valid <= 1'b0;
                    // a write is finished once its last byte is on the line.
                    if (tx_ready) begin
                        cmd_ready <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_valid_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> !cmd_ready);

endmodule

//--- hdl/uart_mem_system.sv
module uart_mem_system (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_start,
    input  logic                      cmd_write,
    output logic                      cmd_ready,
    input  logic [mem_pkg::ADDR_W-1:0] addr,
    input  logic [mem_pkg::DATA_W-1:0] wdata,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic                      rdata_valid
);

    logic host_line;     // bridge to target.
    logic reply_line;    // target back to bridge.

    uart_mem_bridge u_bridge (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .serial_out  (host_line),
        .serial_in   (reply_line)
    );

    uart_mem_target u_target (
        .clk        (clk),
        .rst_n      (rst_n),
        .serial_in  (host_line),
        .serial_out (reply_line)
    );

endmodule

//--- hdl/uart_mem_target.sv
module uart_mem_target (
    input  logic clk,
    input  logic rst_n,
    input  logic serial_in,
    output logic serial_out
);

    typedef enum logic [2:0] {PARSE, WRITE, LOAD, SEND, GAP} state_t;

    state_t                      state;
    logic [3:0]                  cnt;       // request bytes in, then reply bytes out.
    logic [7:0]                  cmd_q;
    logic [mem_pkg::ADDR_W-1:0]  addr_q;
    logic [mem_pkg::DATA_W-1:0]  wdata_q;
    logic [mem_pkg::DATA_W-1:0]  reply;
    logic [mem_pkg::DATA_W-1:0]  mem [mem_pkg::MEM_WORDS];
    logic [mem_pkg::MEM_INDEX_W-1:0] mem_index;
    logic                        tx_start;
    logic [7:0]                  tx_data;
    logic                        tx_ready;
    logic [7:0]                  rx_data;
    logic                        rx_valid;

    // word index, skipping the byte offset bits.
    assign mem_index = addr_q[$clog2(mem_pkg::BYTES_PER_WORD) +: mem_pkg::MEM_INDEX_W];

    uart_rx u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .line  (serial_in),
        .data  (rx_data),
        .valid (rx_valid)
    );

    uart_tx u_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .start (tx_start),
        .data  (tx_data),
        .ready (tx_ready),
        .line  (serial_out)
    );

    always_ff @(posedge clk) begin
        if (state == WRITE) mem[mem_index] <= wdata_q;
    end

    always_ff @(posedge clk) begin
        if (state == PARSE && rx_valid) begin
            if (cnt >= 4'd1 && cnt <= 4'(mem_pkg::BYTES_PER_WORD))
                addr_q <= {addr_q[mem_pkg::ADDR_W-9:0], rx_data};
            else if (cnt != 4'd0)
                wdata_q <= {wdata_q[mem_pkg::DATA_W-9:0], rx_data};
        end
        if (state == LOAD) reply <= mem[mem_index];
        else if (state == SEND && tx_ready) reply <= reply << 8;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= PARSE;
            cnt      <= '0;
            cmd_q    <= '0;
            tx_start <= 1'b0;
            tx_data  <= '0;
        end else begin
            case (state)
                PARSE: if (rx_valid) begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd0) cmd_q <= rx_data;
                    // last address byte of a read, or last data byte of a write.
                    if (cnt == 4'(mem_pkg::BYTES_PER_WORD) && cmd_q == mem_pkg::CMD_READ)
                        state <= LOAD;
                    else if (cnt == 4'(2 * mem_pkg::BYTES_PER_WORD))
                        state <= WRITE;
                end
                WRITE: begin
                    cnt   <= '0;
                    state <= PARSE;
                end
                LOAD: begin
                    cnt   <= '0;
                    state <= SEND;
                end
                SEND: if (tx_ready) begin
                    tx_start <= 1'b1;
                    tx_data  <= reply[mem_pkg::DATA_W-1 -: 8];
                    cnt      <= cnt + 1'b1;
                    state    <= GAP;
                end
                GAP: begin
                    tx_start <= 1'b0;
                    if (cnt == 4'(mem_pkg::BYTES_PER_WORD)) begin
                        cnt   <= '0;
                        state <= PARSE;
                    end else begin
                        state <= SEND;
                    end
                end
                default: state <= PARSE;
            endcase
        end
    end

    a_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt <= 4'd9);

endmodule

//--- hdl/uart_pkg.sv
package uart_pkg;

    // serial timing, in clock cycles.
    localparam int CLKS_PER_BIT = 8;

    // payload bits per frame, sent lsb first.
    localparam int DATA_BITS = 8;

    // start bit, payload and stop bit.
    localparam int FRAME_CLKS = (DATA_BITS + 2) * CLKS_PER_BIT;

endpackage

//--- hdl/uart_rx.sv
module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       line,
    output logic [7:0] data,
    output logic       valid
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;
    typedef logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] baud_t;
    typedef logic [$clog2(uart_pkg::DATA_BITS)-1:0]    bit_t;

    state_t     state;
    baud_t      baud_cnt;
    bit_t       bit_cnt;
    logic [7:0] shreg;
    logic       line_q;    // registered copy of the serial input.
    logic       bit_done;
    logic       half_done;

    assign bit_done  = (baud_cnt == baud_t'(uart_pkg::CLKS_PER_BIT - 1));
    assign half_done = (baud_cnt == baud_t'(uart_pkg::CLKS_PER_BIT / 2 - 1));
    assign data      = shreg;    // holds until the next frame's first data bit.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '0;
            line_q   <= 1'b1;
            valid    <= 1'b0;
        end else begin
            line_q <= line;
            valid  <= 1'b0;
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    if (!line_q) state <= START;
                end
                START: begin
                    // recheck the start bit half a bit in, then step whole bits.
                    if (half_done) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= line_q ? IDLE : DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        shreg    <= {line_q, shreg[7:1]};    // lsb arrives first.
                        if (bit_cnt == bit_t'(uart_pkg::DATA_BITS - 1)) state <= STOP;
                        else bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        valid    <= 1'b1;
                        state    <= IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the sample taken one cycle before valid is the stop bit.
    a_stop_bit_high: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> $past(line_q));

endmodule

//--- hdl/uart_tx.sv
module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic [7:0] data,
    output logic       ready,
    output logic       line
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;
    typedef logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] baud_t;
    typedef logic [$clog2(uart_pkg::DATA_BITS)-1:0]    bit_t;

    state_t     state;
    baud_t      baud_cnt;
    bit_t       bit_cnt;
    logic [7:0] shreg;
    logic       bit_done;

    assign bit_done = (baud_cnt == baud_t'(uart_pkg::CLKS_PER_BIT - 1));
    assign ready    = (state == IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '0;
            line     <= 1'b1;
        end else begin
            baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    if (start) begin
                        shreg <= data;
                        line  <= 1'b0;    // start bit.
                        state <= START;
                    end
                end
                START: if (bit_done) begin
                    line    <= shreg[0];
                    shreg   <= shreg >> 1;
                    bit_cnt <= '0;
                    state   <= DATA;
                end
                DATA: if (bit_done) begin
                    if (bit_cnt == bit_t'(uart_pkg::DATA_BITS - 1)) begin
                        line  <= 1'b1;    // stop bit.
                        state <= STOP;
                    end else begin
                        line    <= shreg[0];
                        shreg   <= shreg >> 1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                STOP: if (bit_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    a_start_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ready);

endmodule

//--- sources.f
hdl/uart_pkg.sv
hdl/mem_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_mem_bridge.sv
hdl/uart_mem_target.sv
hdl/uart_mem_system.sv
verif/tb_uart_mem_system.sv

//--- verif/tb_uart_mem_system.sv
module tb_uart_mem_system;

    localparam int WAIT_LIMIT = 12 * uart_pkg::FRAME_CLKS;

    logic                       clk;
    logic                       rst_n;
    logic                       cmd_start;
    logic                       cmd_write;
    logic                       cmd_ready;
    logic [mem_pkg::ADDR_W-1:0] addr;
    logic [mem_pkg::DATA_W-1:0] wdata;
    logic [mem_pkg::DATA_W-1:0] rdata;
    logic                       rdata_valid;
    logic                       read_pending;    // last accepted command was a read.
    int                         busy_cycles;     // cycles since the last accepted command.

    logic [mem_pkg::DATA_W-1:0] model [int];
    logic [mem_pkg::ADDR_W-1:0] addrs [$];
    int                         order [$];

    uart_mem_system uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) read_pending <= 1'b0;
        else if (cmd_start && cmd_ready) read_pending <= !cmd_write;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) busy_cycles <= 0;
        else if (cmd_start && cmd_ready) busy_cycles <= 0;
        else busy_cycles <= busy_cycles + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |=> !rdata_valid)
        else abort_run("rdata_valid stayed high for more than one cycle");

    a_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_start && cmd_ready) |=> !cmd_ready)
        else abort_run("cmd_ready did not drop after a command was accepted");

    // a read only completes through its rdata_valid pulse.
    a_read_done_order: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ready) && read_pending |-> $past(rdata_valid))
        else abort_run("cmd_ready returned before the read data was delivered");

    // nine whole frames leave the transmitter before a write completes.
    a_write_done_late: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ready) && !read_pending |-> busy_cycles >= 9 * uart_pkg::FRAME_CLKS)
        else abort_run("cmd_ready returned before all write bytes were sent");

    // address divided by the word size, wrapped to the memory depth.
    function automatic int word_index(input logic [mem_pkg::ADDR_W-1:0] a);
        return int'((a / mem_pkg::BYTES_PER_WORD) % mem_pkg::MEM_WORDS);
    endfunction

    function automatic logic [mem_pkg::ADDR_W-1:0] addr_for_index(input int index);
        logic [mem_pkg::ADDR_W-1:0] a;
        a = $urandom();
        a[2 +: mem_pkg::MEM_INDEX_W] = index[mem_pkg::MEM_INDEX_W-1:0];
        return a;
    endfunction

    task automatic shuffle(inout int q[$]);
        int j;
        int tmp;
        for (int i = q.size() - 1; i > 0; i--) begin
            j = int'($urandom() % 32'(i + 1));
            tmp = q[i];
            q[i] = q[j];
            q[j] = tmp;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("Mismatch in %s: expected %08h, actual %08h",
                                     name, expected, actual));
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (cmd_ready !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ready !== 1'b1) abort_run("transaction never finished, cmd_ready stayed low");
    endtask

    task automatic issue(input logic write, input logic [31:0] a, input logic [31:0] d);
        wait_ready();
        cmd_start = 1'b1;
        cmd_write = write;
        addr      = a;
        wdata     = d;
        @(negedge clk);
        cmd_start = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] a, input logic [31:0] d);
        issue(1'b1, a, d);
        model[word_index(a)] = d;
    endtask

    task automatic read_check(input string name, input logic [31:0] a);
        int n;
        issue(1'b0, a, '0);
        n = 0;
        while (rdata_valid !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rdata_valid !== 1'b1) abort_run("read never finished, no rdata_valid pulse");
        check_word(name, model[word_index(a)], rdata);
    endtask

    initial begin
        logic [31:0] a;
        void'($urandom(65));
        rst_n     = 1'b0;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        addr      = '0;
        wdata     = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_word("reset cmd_ready", 32'd1, 32'(cmd_ready));
        check_word("reset rdata_valid", 32'd0, 32'(rdata_valid));
        check_word("reset rdata", 32'd0, rdata);

        a = $urandom();
        write_word(a, $urandom());
        read_check("write then read", a);

        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) order.push_back(i);
        shuffle(order);
        for (int i = 0; i < 20; i++) begin
            addrs.push_back(addr_for_index(order[i]));
            write_word(addrs[i], $urandom());
        end
        order.delete();
        for (int i = 0; i < 20; i++) order.push_back(i);
        shuffle(order);
        foreach (order[k]) begin
            a = addrs[order[k]];
            if (k % 2 == 1) a = a ^ ((($urandom() % 32'd255) + 32'd1) << 8);    // alias above the index.
            read_check($sformatf("shuffled read %0d", k), a);
        end

        write_word(addrs[0], $urandom());
        read_check("overwrite", addrs[0]);

        // a strobe in the middle of a write must be dropped.
        write_word(addrs[1], $urandom());
        repeat (3) @(negedge clk);
        assert (cmd_ready === 1'b0)
            else abort_run("cmd_ready high while a write was in flight");
        cmd_start = 1'b1;
        cmd_write = 1'b1;
        addr      = addrs[2];
        wdata     = ~model[word_index(addrs[2])];
        @(negedge clk);
        cmd_start = 1'b0;
        read_check("busy strobe", addrs[2]);
        read_check("busy write", addrs[1]);

        wait_ready();
        $display("sim passed");
        $finish;
    end

endmodule
